// ==== logic/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

//////////////////////////////////////////////////
// Datapath sizing
//////////////////////////////////////////////////

// Data word and byte address width
`define WORD_WIDTH 16

// Architectural registers, r0 is an ordinary register here
`define NUM_REGS 16
`define REG_IDX_WIDTH 4       // log2 of NUM_REGS

//////////////////////////////////////////////////
// Instruction memory
//////////////////////////////////////////////////

// Depth in 16-bit words, so 128 bytes of program space
`define IMEM_DEPTH 64
`define IMEM_ADDR_WIDTH 6     // Word index width, log2 of IMEM_DEPTH

// Sequential step of the PC in bytes
`define PC_STEP 2

`endif

// ==== logic/isaPkg.sv ====
package isaPkg;

  //////////////////////////////////////////////////
  // Opcodes, held in instr[15:12]
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,    // rd = rs + rt, sets Z V N
    OP_SUB = 4'd1,    // rd = rs - rt, sets Z V N
    OP_XOR = 4'd2,    // rd = rs ^ rt, sets Z only
    OP_LLB = 4'd10,   // Low byte of rd from imm8
    OP_LHB = 4'd11,   // High byte of rd from imm8
    OP_B   = 4'd12,   // PC-relative conditional branch
    OP_BR  = 4'd13,   // Conditional jump to rs
    OP_HLT = 4'd15    // Stop fetching
  } opcodeE;

  //////////////////////////////////////////////////
  // Branch conditions, held in instr[11:9]
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    CC_NE = 3'b000,   // Z clear
    CC_EQ = 3'b001,   // Z set
    CC_GT = 3'b010,   // Z and N both clear
    CC_LT = 3'b011,   // N set
    CC_GE = 3'b100,   // Z set, or Z and N clear
    CC_LE = 3'b101,   // Z or N set
    CC_OV = 3'b110,   // V set
    CC_UN = 3'b111    // Always
  } condE;

  // True for the eight encodings the core implements
  function automatic logic isDefinedOp(logic [3:0] code);
    return code inside {OP_ADD, OP_SUB, OP_XOR, OP_LLB,
                        OP_LHB, OP_B, OP_BR, OP_HLT};
  endfunction

endpackage

// ==== logic/pipePkg.sv ====
package pipePkg;

  //////////////////////////////////////////////////
  // Flag register
  //////////////////////////////////////////////////

  // Z in the top bit, then V, then N
  typedef struct packed {
    logic z;   // Result was zero
    logic v;   // Signed overflow
    logic n;   // Result negative
  } flagsT;

  //////////////////////////////////////////////////
  // Fetch control
  //////////////////////////////////////////////////

  // FS_HALT is only left through reset
  typedef enum logic {
    FS_RUN  = 1'b0,   // PC advancing or following redirects
    FS_HALT = 1'b1    // PC frozen and no more valid slots
  } fetchStateE;

endpackage

// ==== logic/fetchIf.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

// Link between the fetch and execute stages
interface fetchIf;

  // Forward path, fetch to execute
  logic                   valid;   // instr and pc hold a live instruction
  logic [`WORD_WIDTH-1:0] instr;   // Fetched instruction word
  logic [`WORD_WIDTH-1:0] pc;      // Byte address of instr

  // Return path, execute to fetch
  logic                   redirect;  // One-cycle pulse on a taken branch
  logic [`WORD_WIDTH-1:0] target;    // New PC, meaningful with redirect
  logic                   halt;      // Level, stays up once HLT executed

  modport fetch (
    output valid, instr, pc,
    input  redirect, target, halt
  );

  modport execute (
    input  valid, instr, pc,
    output redirect, target, halt
  );

endinterface

`default_nettype wire

// ==== logic/pcControl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module pcControl (
  input  wire isaPkg::condE          cond,     // ccc field
  input  wire logic [8:0]            offset,   // Signed, in halfwords
  input  wire pipePkg::flagsT        flags,
  input  wire logic [`WORD_WIDTH-1:0] rsVal,   // Jump address for BR
  input  wire logic                  isBranch, // B or BR in execute
  input  wire logic                  isReg,    // BR rather than B
  input  wire logic [`WORD_WIDTH-1:0] pcIn,    // Address of the branch itself
  output      logic [`WORD_WIDTH-1:0] pcOut,
  output      logic                  taken
);

  logic                   condMet;
  logic [`WORD_WIDTH-1:0] pcPlus2;
  logic [`WORD_WIDTH-1:0] relTarget;

  //////////////////////////////////////////////////
  // Condition table
  //////////////////////////////////////////////////
  always_comb begin
    case (cond)
      isaPkg::CC_NE: condMet = !flags.z;
      isaPkg::CC_EQ: condMet = flags.z;
      isaPkg::CC_GT: condMet = !flags.z && !flags.n;
      isaPkg::CC_LT: condMet = flags.n;
      isaPkg::CC_GE: condMet = flags.z || (!flags.z && !flags.n);
      isaPkg::CC_LE: condMet = flags.z || flags.n;
      isaPkg::CC_OV: condMet = flags.v;
      isaPkg::CC_UN: condMet = 1'b1;           // Unconditional
      default:       condMet = 1'b0;
    endcase
  end

  // Fall-through address
  assign pcPlus2 = pcIn + `WORD_WIDTH'(`PC_STEP);

  // Sign extend, then scale halfwords to bytes
  assign relTarget = pcPlus2 + {{(`WORD_WIDTH-10){offset[8]}}, offset, 1'b0};

  assign taken = isBranch && condMet;
  assign pcOut = taken ? (isReg ? rsVal : relTarget) : pcPlus2;

  // Instructions only ever sit on halfword boundaries
  always_comb begin
    evenPc: assert final (pcIn[0] == 1'b0)
      else $error("odd PC %h reached branch logic", pcIn);
  end

endmodule

`default_nettype wire

// ==== logic/fetchStage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module fetchStage (
  input  wire logic                       clk,
  input  wire logic                       rstN,
  input  wire logic                       loadEn,     // Program load strobe
  input  wire logic [`IMEM_ADDR_WIDTH-1:0] loadAddr,  // Word index
  input  wire logic [`WORD_WIDTH-1:0]     loadData,
  fetchIf.fetch                           fIf,
  output      logic [`WORD_WIDTH-1:0]     pc,         // Address being fetched
  output      logic                       halted
);

  logic [`WORD_WIDTH-1:0] pcReg;
  pipePkg::fetchStateE    state;
  logic                   advance;    // Normal sequential fetch this cycle

  // Instruction store, no reset on the array
  logic [`WORD_WIDTH-1:0] imem [`IMEM_DEPTH];

  //////////////////////////////////////////////////
  // Load port
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (loadEn)
      imem[loadAddr] <= loadData;   // Testbench fills this while in reset
  end

  // Only a running stage with no redirect or halt pending moves forward
  assign advance = (state == pipePkg::FS_RUN) && !fIf.halt && !fIf.redirect;

  //////////////////////////////////////////////////
  // PC, valid and run/halt state
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= pipePkg::FS_RUN;
      pcReg     <= '0;
      fIf.valid <= 1'b0;
      fIf.pc    <= '0;
    end else if (state == pipePkg::FS_RUN) begin
      if (fIf.halt) begin
        state     <= pipePkg::FS_HALT;   // PC holds the slot after HLT
        fIf.valid <= 1'b0;
      end else if (fIf.redirect) begin
        pcReg     <= fIf.target;
        fIf.valid <= 1'b0;               // Squash the wrong-path slot
      end else begin
        pcReg     <= pcReg + `WORD_WIDTH'(`PC_STEP);
        fIf.valid <= 1'b1;
        fIf.pc    <= pcReg;
      end
    end
  end

  // Instruction word is payload only, valid qualifies it
  always_ff @(posedge clk) begin
    if (advance)
      fIf.instr <= imem[pcReg[`IMEM_ADDR_WIDTH:1]];   // Byte to word index
  end

  assign pc     = pcReg;
  assign halted = (state == pipePkg::FS_HALT);

  // Halt is sticky and nothing issues behind it
  haltSticky: assert property (@(posedge clk) disable iff (!rstN)
    (state == pipePkg::FS_HALT) |=> (state == pipePkg::FS_HALT) && !fIf.valid)
    else $error("fetch left FS_HALT or issued a slot");

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module executeStage (
  input  wire logic                       clk,
  input  wire logic                       rstN,
  fetchIf.execute                         fIf,
  input  wire logic [`REG_IDX_WIDTH-1:0]  dbgAddr,
  output      logic [`WORD_WIDTH-1:0]     dbgData
);

  localparam int WW = `WORD_WIDTH;

  // Decode fields
  isaPkg::opcodeE            op;
  logic [`REG_IDX_WIDTH-1:0] rd, rs, rt;
  logic [7:0]                imm8;

  logic          active;      // Valid and not yet halted
  logic          haltSeen;    // HLT already retired
  logic          regWrite;
  logic          isBranch;
  logic          isReg;
  logic          taken;

  logic [WW-1:0] rdVal, rsVal, rtVal;
  logic [WW-1:0] sum, diff, result;
  logic          addOvf, subOvf;
  logic [WW-1:0] nextPc;

  pipePkg::flagsT flags, newFlags;

  logic [WW-1:0] regs [`NUM_REGS];

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  assign op   = isaPkg::opcodeE'(fIf.instr[15:12]);
  assign rd   = fIf.instr[11:8];
  assign rs   = fIf.instr[7:4];    // Also the BR jump register
  assign rt   = fIf.instr[3:0];
  assign imm8 = fIf.instr[7:0];

  assign active   = fIf.valid && !haltSeen;
  assign isBranch = (op == isaPkg::OP_B) || (op == isaPkg::OP_BR);
  assign isReg    = (op == isaPkg::OP_BR);

  // Register file reads, all combinational
  assign rdVal   = regs[rd];
  assign rsVal   = regs[rs];
  assign rtVal   = regs[rt];
  assign dbgData = regs[dbgAddr];

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////
  assign sum  = rsVal + rtVal;     // Wraps
  assign diff = rsVal - rtVal;

  // Same-sign operands, different-sign result
  assign addOvf = (rsVal[WW-1] == rtVal[WW-1]) && (sum[WW-1] != rsVal[WW-1]);
  assign subOvf = (rsVal[WW-1] != rtVal[WW-1]) && (diff[WW-1] != rsVal[WW-1]);

  always_comb begin
    result   = '0;
    regWrite = 1'b0;
    newFlags = flags;              // Untouched unless the op sets them
    case (op)
      isaPkg::OP_ADD: begin
        result   = sum;
        regWrite = 1'b1;
        newFlags = '{z: (sum == '0), v: addOvf, n: sum[WW-1]};
      end
      isaPkg::OP_SUB: begin
        result   = diff;
        regWrite = 1'b1;
        newFlags = '{z: (diff == '0), v: subOvf, n: diff[WW-1]};
      end
      isaPkg::OP_XOR: begin
        result     = rsVal ^ rtVal;
        regWrite   = 1'b1;
        newFlags.z = ((rsVal ^ rtVal) == '0);   // Z only
      end
      isaPkg::OP_LLB: begin
        result   = {rdVal[WW-1:8], imm8};
        regWrite = 1'b1;
      end
      isaPkg::OP_LHB: begin
        result   = {imm8, rdVal[7:0]};
        regWrite = 1'b1;
      end
      default: ;                   // Branches and HLT write nothing
    endcase
  end

  //////////////////////////////////////////////////
  // State updates
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
      flags    <= '0;
      haltSeen <= 1'b0;
    end else if (active) begin
      if (regWrite)
        regs[rd] <= result;
      flags <= newFlags;
      if (op == isaPkg::OP_HLT)
        haltSeen <= 1'b1;
    end
  end

  // Next-PC and condition check
  pcControl uPcControl (
    .cond     (isaPkg::condE'(fIf.instr[11:9])),
    .offset   (fIf.instr[8:0]),
    .flags    (flags),
    .rsVal    (rsVal),
    .isBranch (isBranch),
    .isReg    (isReg),
    .pcIn     (fIf.pc),
    .pcOut    (nextPc),
    .taken    (taken)
  );

  assign fIf.redirect = active && taken;
  assign fIf.target   = nextPc;
  assign fIf.halt     = haltSeen || (active && op == isaPkg::OP_HLT);  // Held as a level

  // Fetch must squash the slot behind a redirect
  redirectPulse: assert property (@(posedge clk) disable iff (!rstN)
    fIf.redirect |=> !fIf.valid && !fIf.redirect)
    else $error("wrong-path slot reached execute");

  validOpcode: assert property (@(posedge clk) disable iff (!rstN)
    fIf.valid |-> isaPkg::isDefinedOp(fIf.instr[15:12]))
    else $error("undefined opcode %h at %h", fIf.instr[15:12], fIf.pc);

endmodule

`default_nettype wire

// ==== logic/cpuCore.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module cpuCore (
  input  wire logic                        clk,
  input  wire logic                        rstN,
  // Program load
  input  wire logic                        loadEn,
  input  wire logic [`IMEM_ADDR_WIDTH-1:0] loadAddr,
  input  wire logic [`WORD_WIDTH-1:0]      loadData,
  // Register debug read
  input  wire logic [`REG_IDX_WIDTH-1:0]   dbgAddr,
  output      logic [`WORD_WIDTH-1:0]      dbgData,
  // Status
  output      logic [`WORD_WIDTH-1:0]      pc,
  output      logic                        halted     // Rises at end of program
);

  fetchIf uFetchIf ();

  //////////////////////////////////////////////////
  // Stage 1, PC and instruction memory
  //////////////////////////////////////////////////
  fetchStage uFetch (
    .clk      (clk),
    .rstN     (rstN),
    .loadEn   (loadEn),
    .loadAddr (loadAddr),
    .loadData (loadData),
    .fIf      (uFetchIf.fetch),
    .pc       (pc),
    .halted   (halted)
  );

  //////////////////////////////////////////////////
  // Stage 2, decode through writeback
  //////////////////////////////////////////////////
  executeStage uExecute (
    .clk     (clk),
    .rstN    (rstN),
    .fIf     (uFetchIf.execute),
    .dbgAddr (dbgAddr),
    .dbgData (dbgData)
  );

endmodule

`default_nettype wire

// ==== dv/cpuCoreTb.sv ====
`timescale 1ns/1ns

`include "cpu_config.svh"

module cpuCoreTb;

  // Seven programs in all, each loaded, run, read back and held a little
  localparam int TIMEOUT_CYCLES =
    7 * (`IMEM_DEPTH + 4 + 2 * `IMEM_DEPTH + `NUM_REGS + 12);

  // SUB operands per condition in NE EQ GT LT GE LE OV UN order
  localparam logic [3:0] CondSrcA [8] = '{4'd1, 4'd1, 4'd2, 4'd2, 4'd1, 4'd1, 4'd3, 4'd1};
  localparam logic [3:0] CondSrcB [8] = '{4'd1, 4'd1, 4'd1, 4'd1, 4'd2, 4'd2, 4'd1, 4'd2};

  logic                         clk;
  logic                         rstN;
  logic                         loadEn;
  logic [`IMEM_ADDR_WIDTH-1:0]  loadAddr;
  logic [`WORD_WIDTH-1:0]       loadData;
  logic [`REG_IDX_WIDTH-1:0]    dbgAddr;
  logic [`WORD_WIDTH-1:0]       dbgData;
  logic [`WORD_WIDTH-1:0]       pc;
  logic                         halted;

  logic [15:0] prog [$];                  // Program under construction
  logic [15:0] image [`IMEM_DEPTH];       // Full memory image as loaded
  logic [15:0] modelRegs [`NUM_REGS];
  logic [15:0] modelPc;                   // HLT address plus 2
  logic [31:0] rngState = 32'h2b4059e2;
  int          cycleCount = 0;

  cpuCore uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                // 4 ns period
  end

  //////////////////////////////////////////////////
  // Program builder
  //////////////////////////////////////////////////
  function automatic logic [15:0] regInstr(isaPkg::opcodeE op, logic [3:0] rd,
                                           logic [3:0] rs, logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] immInstr(isaPkg::opcodeE op, logic [3:0] rd,
                                           logic [7:0] imm);
    return {op, rd, imm};                 // LLB and LHB
  endfunction

  function automatic logic [15:0] branchInstr(isaPkg::condE cc, int off);
    logic [8:0] o;
    o = 9'(off);                          // Halfwords past PC+2
    return {isaPkg::OP_B, cc, o};
  endfunction

  function automatic logic [15:0] jumpRegInstr(isaPkg::condE cc, logic [3:0] rs);
    return {isaPkg::OP_BR, cc, 1'b0, rs, 4'h0};
  endfunction

  function automatic logic [15:0] haltInstr();
    return {isaPkg::OP_HLT, 12'h000};
  endfunction

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  //////////////////////////////////////////////////
  // Reference model built from the ISA rules
  //////////////////////////////////////////////////
  function automatic logic condHolds(logic [2:0] cc, logic z, logic v, logic n);
    case (cc)
      isaPkg::CC_NE: return !z;
      isaPkg::CC_EQ: return z;
      isaPkg::CC_GT: return !z && !n;
      isaPkg::CC_LT: return n;
      isaPkg::CC_GE: return z || !n;
      isaPkg::CC_LE: return z || n;
      isaPkg::CC_OV: return v;
      default:       return 1'b1;         // UN
    endcase
  endfunction

  task automatic modelProgram();
    logic [15:0] ir, a, b, res, pcM;
    logic        z, v, n, done;
    int          sres;
    int          steps;
    for (int i = 0; i < `NUM_REGS; i++)
      modelRegs[i] = '0;
    {z, v, n} = 3'b000;
    pcM = '0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 4 * `IMEM_DEPTH) begin
      ir = image[pcM[`IMEM_ADDR_WIDTH:1]];
      a = modelRegs[ir[7:4]];
      b = modelRegs[ir[3:0]];
      pcM = pcM + 16'd2;                  // Successor unless a branch wins
      steps++;
      case (ir[15:12])
        isaPkg::OP_ADD, isaPkg::OP_SUB: begin
          if (ir[15:12] == isaPkg::OP_ADD) begin
            res = a + b;
            sres = int'($signed(a)) + int'($signed(b));
          end else begin
            res = a - b;
            sres = int'($signed(a)) - int'($signed(b));
          end
          v = (sres > 32767) || (sres < -32768);   // Outside the 16-bit signed range
          z = (res == 16'd0);
          n = res[15];
          modelRegs[ir[11:8]] = res;
        end
        isaPkg::OP_XOR: begin
          res = a ^ b;
          z = (res == 16'd0);
          modelRegs[ir[11:8]] = res;
        end
        isaPkg::OP_LLB: modelRegs[ir[11:8]][7:0] = ir[7:0];
        isaPkg::OP_LHB: modelRegs[ir[11:8]][15:8] = ir[7:0];
        isaPkg::OP_B:
          if (condHolds(ir[11:9], z, v, n))
            pcM = pcM + {{6{ir[8]}}, ir[8:0], 1'b0};
        isaPkg::OP_BR:
          if (condHolds(ir[11:9], z, v, n))
            pcM = a;
        default: done = 1'b1;             // HLT
      endcase
    end
    modelPc = pcM;
    if (!done) begin
      $display("Reference model ran %0d steps without reaching HLT", steps);
      $display(">>> FAIL");
      $fatal(1, "model runaway");
    end
  endtask

  //////////////////////////////////////////////////
  // DUT access and checking
  //////////////////////////////////////////////////
  task automatic checkValue(string testName, string what, logic [15:0] exp, logic [15:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s %s: expected %h, actual %h", testName, what, exp, act);
      $display(">>> FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic readReg(input int idx, output logic [15:0] val);
    @(negedge clk);
    dbgAddr = idx[3:0];
    #1;                                   // Settled well before the next rise
    val = dbgData;
  endtask

  // Unused words of the memory image hold HLT tagged with their own address
  task automatic loadAndReset();
    for (int i = 0; i < `IMEM_DEPTH; i++)
      image[i] = (i < prog.size()) ? prog[i] : {isaPkg::OP_HLT, 6'h00, 6'(i)};
    @(negedge clk);
    rstN = 1'b0;
    for (int i = 0; i < `IMEM_DEPTH; i++) begin
      loadEn = 1'b1;
      loadAddr = `IMEM_ADDR_WIDTH'(i);
      loadData = image[i];
      @(negedge clk);
    end
    loadEn = 1'b0;
    repeat (3) @(negedge clk);            // Reset runs 3 cycles past the last write
    rstN = 1'b1;
  endtask

  task automatic executeProgram(string testName);
    logic [15:0] val;
    loadAndReset();
    while (!halted)
      @(negedge clk);
    modelProgram();
    for (int r = 0; r < `NUM_REGS; r++) begin
      readReg(r, val);
      checkValue(testName, $sformatf("r%0d", r), modelRegs[r], val);
    end
    checkValue(testName, "pc", modelPc, pc);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic aluBasics();
    prog = {};
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd1, 8'h34));
    prog.push_back(immInstr(isaPkg::OP_LHB, 4'd1, 8'h12));   // r1 = 1234
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd2, 8'hff));
    prog.push_back(immInstr(isaPkg::OP_LHB, 4'd2, 8'hff));   // r2 = ffff
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd3, 8'h01));
    prog.push_back(regInstr(isaPkg::OP_ADD, 4'd4, 4'd2, 4'd3));   // Wraps to 0
    prog.push_back(regInstr(isaPkg::OP_SUB, 4'd5, 4'd3, 4'd2));
    prog.push_back(regInstr(isaPkg::OP_XOR, 4'd6, 4'd1, 4'd2));
    prog.push_back(regInstr(isaPkg::OP_ADD, 4'd7, 4'd1, 4'd1));
    prog.push_back(immInstr(isaPkg::OP_LHB, 4'd8, 8'h80));
    prog.push_back(regInstr(isaPkg::OP_SUB, 4'd9, 4'd3, 4'd8));   // Signed overflow
    prog.push_back(haltInstr());
    executeProgram("aluBasics");
  endtask

  // Not-taken marker goes to r4+2k and taken marker to r5+2k
  task automatic conditionCodes();
    int c;
    for (int half = 0; half < 2; half++) begin
      prog = {};
      prog.push_back(immInstr(isaPkg::OP_LLB, 4'd1, 8'd5));
      prog.push_back(immInstr(isaPkg::OP_LLB, 4'd2, 8'd7));
      prog.push_back(immInstr(isaPkg::OP_LHB, 4'd3, 8'h80));
      for (int k = 0; k < 4; k++) begin
        c = half * 4 + k;
        prog.push_back(regInstr(isaPkg::OP_SUB, 4'd15, CondSrcA[c], CondSrcB[c]));
        prog.push_back(branchInstr(isaPkg::condE'(c[2:0]), 2));
        prog.push_back(immInstr(isaPkg::OP_LLB, 4'(4 + 2 * k), 8'(16 * c + 1)));
        prog.push_back(branchInstr(isaPkg::CC_UN, 1));
        prog.push_back(immInstr(isaPkg::OP_LLB, 4'(5 + 2 * k), 8'(16 * c + 2)));
      end
      prog.push_back(haltInstr());
      executeProgram($sformatf("conditions%0d", half));
    end
  endtask

  task automatic jumpRegister();
    prog = {};
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd1, 8'd16));  // Byte address of word 8
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd2, 8'd1));
    prog.push_back(regInstr(isaPkg::OP_SUB, 4'd15, 4'd2, 4'd2));   // Z set
    prog.push_back(jumpRegInstr(isaPkg::CC_NE, 4'd1));      // Falls through
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd4, 8'h44));
    prog.push_back(jumpRegInstr(isaPkg::CC_EQ, 4'd1));
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd5, 8'h55));
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd6, 8'h66));
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd7, 8'h77));  // Jump target
    prog.push_back(haltInstr());
    executeProgram("jumpRegister");
  endtask

  task automatic branchSquash();
    logic [15:0] val;
    prog = {};
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd1, 8'd3));
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd2, 8'd3));
    prog.push_back(regInstr(isaPkg::OP_SUB, 4'd15, 4'd1, 4'd2));
    prog.push_back(branchInstr(isaPkg::CC_EQ, 1));          // Taken
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd3, 8'hee));  // Shadow slot
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd4, 8'h44));
    prog.push_back(branchInstr(isaPkg::CC_NE, 1));          // Not taken
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd5, 8'h55));
    prog.push_back(haltInstr());
    executeProgram("branchSquash");
    readReg(3, val);
    checkValue("branchSquash", "shadow r3", 16'h0000, val);
    readReg(5, val);
    checkValue("branchSquash", "fall-through r5", 16'h0055, val);
  endtask

  task automatic randomAlu();
    int             sel;
    isaPkg::opcodeE op;
    prog = {};
    for (int r = 1; r <= 8; r++) begin
      rngState = xorshift32(rngState);
      prog.push_back(immInstr(isaPkg::OP_LLB, 4'(r), rngState[7:0]));
      prog.push_back(immInstr(isaPkg::OP_LHB, 4'(r), rngState[15:8]));
    end
    for (int k = 0; k < 40; k++) begin
      rngState = xorshift32(rngState);
      sel = int'(rngState % 32'd3);
      case (sel)
        0:       op = isaPkg::OP_ADD;
        1:       op = isaPkg::OP_SUB;
        default: op = isaPkg::OP_XOR;
      endcase
      prog.push_back(regInstr(op, rngState[11:8], rngState[15:12], rngState[19:16]));
    end
    prog.push_back(haltInstr());
    executeProgram("randomAlu");
  endtask

  task automatic haltHold();
    prog = {};
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd1, 8'd1));
    prog.push_back(branchInstr(isaPkg::CC_UN, 2));          // Over an early HLT
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd2, 8'd2));
    prog.push_back(haltInstr());
    prog.push_back(immInstr(isaPkg::OP_LLB, 4'd3, 8'd3));
    prog.push_back(regInstr(isaPkg::OP_ADD, 4'd4, 4'd1, 4'd3));
    prog.push_back(haltInstr());
    executeProgram("haltHold");
    repeat (10) begin
      @(negedge clk);
      checkValue("haltHold", "halted", 16'h0001, {15'h0000, halted});
      checkValue("haltHold", "held pc", modelPc, pc);
    end
  endtask

  //////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////
  initial begin
    rstN = 1'b0;
    loadEn = 1'b0;
    loadAddr = '0;
    loadData = '0;
    dbgAddr = '0;
    aluBasics();
    conditionCodes();
    jumpRegister();
    branchSquash();
    randomAlu();
    haltHold();
    $display(">>> PASS");
    $finish;
  end

  initial begin
    while (cycleCount < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout, run still going after %0d cycles", cycleCount);
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/isaPkg.sv
logic/pipePkg.sv
logic/fetchIf.sv
logic/pcControl.sv
logic/fetchStage.sv
logic/executeStage.sv
logic/cpuCore.sv
dv/cpuCoreTb.sv

// ==== Makefile ====
# Verilator build and run for the two-stage core

VERILATOR ?= verilator
TOP       ?= cpuCoreTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) logic/cpu_config.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
